/* verilog/dcache_macros.svh */
// Cache geometry and address field positions, included by the cache RTL and testbench
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Direct-mapped geometry
`define DC_LINES 16 // Number of cache lines
`define DC_WORDS 16 // 32-bit words per line

// Byte address layout
// [31 tag 10] [9 index 6] [5 word 2] [1:0 byte, always zero]
`define DC_TAG_LSB  10 // Lowest tag bit
`define DC_IDX_LSB  6  // Lowest line index bit
`define DC_WORD_LSB 2  // Lowest word select bit

`endif

/* verilog/dcache_pkg.sv */
// Shared enum types for the data cache controller, the bus arbiter and their checkers
package dcache_pkg;

	// Which requester currently holds the external memory bus
	typedef enum logic {
		OWN_DCACHE = 1'b0, // Data cache controller
		OWN_IFETCH = 1'b1  // Uncached instruction fetch
	} bus_owner_e;

	// What the cache controller did in the previous cycle
	typedef enum logic [1:0] {
		IDLE  = 2'd0, // No bus activity wanted
		FILL  = 2'd1, // Read miss, line fill in progress
		WRITE = 2'd2  // Write-through pending on the bus
	} fill_state_e;

endpackage

/* verilog/mem_bus_if.sv */
// One requester's view of the shared memory bus, used between the cache and the arbiter
`timescale 1ns/1ps

interface mem_bus_if;
	logic        req;   // Held high until the access completes
	logic        ack;   // Requester owns the bus
	logic [31:0] addr;
	logic [31:0] wdata;
	logic [31:0] rdata; // Valid in the cycle ready is high
	logic        rd;
	logic        wr;
	logic        ready; // One beat completes

	modport master (
		output req,
		output addr,
		output wdata,
		output rd,
		output wr,
		input  ack,
		input  rdata,
		input  ready
	);

	modport arbiter (
		input  req,
		input  addr,
		input  wdata,
		input  rd,
		input  wr,
		output ack,
		output rdata,
		output ready
	);
endinterface

/* verilog/dcache_tag_array.sv */
// Valid bits and tags of the data cache, giving a combinational hit for the addressed line
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_tag_array (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [3:0]  rd_index,
	input  logic [21:0] rd_tag,
	output logic        hit,
	input  logic        wr_en,
	input  logic [3:0]  wr_index,
	input  logic [21:0] wr_tag
);
	logic [`DC_LINES-1:0] valid;
	logic [21:0]          tags [`DC_LINES];

	// Hit needs a valid line and a matching tag
	assign hit = valid[rd_index] && (tags[rd_index] == rd_tag);

	// One valid bit per line
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0; // Whole cache empty
		end else if (wr_en) begin
			valid[wr_index] <= 1'b1; // Line filled
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			tags[wr_index] <= wr_tag;
		end
	end

endmodule

/* verilog/dcache_data_array.sv */
// Line storage of the data cache, one asynchronous read port and one synchronous write port
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_data_array (
	input  logic        clk,
	input  logic [3:0]  rd_index,
	input  logic [3:0]  rd_word,
	output logic [31:0] rd_data,
	input  logic        wr_en,
	input  logic [3:0]  wr_index,
	input  logic [3:0]  wr_word,
	input  logic [31:0] wr_data
);
	logic [31:0] mem [`DC_LINES][`DC_WORDS]; // [line][word]

	// Read hits return data in the request cycle
	assign rd_data = mem[rd_index][rd_word];

	// Fill beats and write-through hits share this port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_index][wr_word] <= wr_data;
		end
	end

endmodule

/* verilog/dcache_ctrl.sv */
// Cache controller handling line fills, write-through bus writes and the core stall
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_ctrl import dcache_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] addr,
	input  logic        rd_req,
	input  logic        wr_req,
	input  logic [31:0] wr_data,
	output logic        rw_wait,
	input  logic        hit,
	output logic        tag_wr_en,
	output logic        data_wr_en,
	output logic [3:0]  data_wr_word,
	output logic [31:0] data_wr_data,
	mem_bus_if.master   bus
);
	logic [31:`DC_IDX_LSB] line;      // Line address of the request
	logic [31:`DC_IDX_LSB] prev_line; // Line address one cycle ago
	logic [3:0]            word;
	logic [3:0]            fill_pos;  // Next word to fetch
	logic [3:0]            beat_pos;  // Word fetched this cycle
	logic                  read_miss;
	logic                  fill_beat;
	logic                  write_beat;
	fill_state_e           state;
	fill_state_e           state_nxt;

	assign line      = addr[31:`DC_IDX_LSB];
	assign word      = addr[`DC_IDX_LSB-1:`DC_WORD_LSB];
	assign read_miss = rd_req && !hit;

	// A fill only carries on if last cycle was filling this same line,
	// otherwise it starts over from word 0
	assign beat_pos = (state == FILL && prev_line == line) ? fill_pos : 4'd0;

	// Reads take priority over a simultaneous write
	assign bus.req   = read_miss || wr_req;
	assign bus.rd    = read_miss && bus.ack;
	assign bus.wr    = wr_req && !read_miss && bus.ack;
	assign bus.wdata = wr_data;

	always_comb begin
		if (read_miss) begin
			bus.addr = {line, beat_pos, {`DC_WORD_LSB{1'b0}}}; // Word-aligned fill read
		end else begin
			bus.addr = addr;
		end
	end

	assign fill_beat  = bus.rd && bus.ready;
	assign write_beat = bus.wr && bus.ready;

	// Core stalls on a miss and until the write beat lands
	assign rw_wait = read_miss || (wr_req && !write_beat);

	// Array updates
	assign tag_wr_en    = fill_beat && (beat_pos == 4'(`DC_WORDS - 1)); // Last beat validates
	assign data_wr_en   = fill_beat || (write_beat && hit);
	assign data_wr_word = fill_beat ? beat_pos : word;
	assign data_wr_data = fill_beat ? bus.rdata : wr_data;

	always_comb begin
		if (read_miss) begin
			state_nxt = FILL;
		end else if (wr_req) begin
			state_nxt = WRITE;
		end else begin
			state_nxt = IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= IDLE;
			fill_pos <= '0;
		end else begin
			state    <= state_nxt;
			fill_pos <= fill_beat ? beat_pos + 4'd1 : beat_pos; // Holds while ready is low
		end
	end

	// Line address history for fill restart
	always_ff @(posedge clk) begin
		prev_line <= line;
	end

endmodule

/* verilog/bus_arbiter.sv */
// Two-master arbiter sharing the memory bus between the data cache and instruction fetch
`timescale 1ns/1ps

module bus_arbiter import dcache_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	mem_bus_if.arbiter   m_dc,
	input  logic         if_req,
	input  logic [31:0]  if_addr,
	output logic         if_ack,
	output logic [31:0]  if_rdata,
	output logic         if_ready,
	output logic [31:0]  mem_addr,
	output logic [31:0]  mem_wdata,
	output logic         mem_rd,
	output logic         mem_wr,
	input  logic [31:0]  mem_rdata,
	input  logic         mem_ready
);
	bus_owner_e owner;  // Current owner, kept as last grant once released
	bus_owner_e grant;
	logic       locked; // Owner holds the bus
	logic       busy;
	logic       owner_req;
	logic       dc_sel;
	logic       if_sel;

	assign busy      = m_dc.req || if_req;
	assign owner_req = (owner == OWN_DCACHE) ? m_dc.req : if_req;

	always_comb begin
		if (locked && owner_req) begin
			grant = owner; // Held until the owner lets go
		end else if (m_dc.req && if_req) begin
			// Favour the one that did not have it last
			grant = (owner == OWN_DCACHE) ? OWN_IFETCH : OWN_DCACHE;
		end else if (if_req) begin
			grant = OWN_IFETCH;
		end else if (m_dc.req) begin
			grant = OWN_DCACHE;
		end else begin
			grant = owner;
		end
	end

	assign dc_sel = m_dc.req && (grant == OWN_DCACHE);
	assign if_sel = if_req && (grant == OWN_IFETCH);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			locked <= 1'b0;
			owner  <= OWN_DCACHE;
		end else begin
			locked <= busy;
			if (busy) begin
				owner <= grant;
			end
		end
	end

	// Steer the owner onto the memory port
	assign mem_addr  = if_sel ? if_addr : m_dc.addr;
	assign mem_wdata = m_dc.wdata;                  // Instruction fetch never writes
	assign mem_rd    = if_sel || (dc_sel && m_dc.rd);
	assign mem_wr    = dc_sel && m_dc.wr;

	// Return path reaches the owner only
	assign m_dc.ack   = dc_sel;
	assign m_dc.rdata = dc_sel ? mem_rdata : '0;
	assign m_dc.ready = dc_sel && mem_ready;
	assign if_ack     = if_sel;
	assign if_rdata   = if_sel ? mem_rdata : '0;
	assign if_ready   = if_sel && mem_ready;

endmodule

/* verilog/dcache_subsys.sv */
// Data-side memory subsystem top, joining the cache, its controller and the bus arbiter
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_subsys (
	input  logic        clk,
	input  logic        rst_n,
	// Core data port
	input  logic [31:0] addr,
	input  logic        rd_req,
	input  logic        wr_req,
	input  logic [31:0] wr_data,
	output logic [31:0] rd_data,
	output logic        rw_wait,
	// Instruction fetch port
	input  logic        if_req,
	output logic        if_ack,
	input  logic [31:0] if_addr,
	output logic [31:0] if_rdata,
	output logic        if_ready,
	// External memory port
	output logic [31:0] mem_addr,
	output logic [31:0] mem_wdata,
	output logic        mem_rd,
	output logic        mem_wr,
	input  logic [31:0] mem_rdata,
	input  logic        mem_ready
);
	logic [21:0] tag;
	logic [3:0]  index;
	logic [3:0]  word;
	logic        hit;
	logic        tag_wr_en;
	logic        data_wr_en;
	logic [3:0]  data_wr_word;
	logic [31:0] data_wr_data;

	mem_bus_if dc_bus ();

	assign tag   = addr[31:`DC_TAG_LSB];
	assign index = addr[`DC_TAG_LSB-1:`DC_IDX_LSB];
	assign word  = addr[`DC_IDX_LSB-1:`DC_WORD_LSB];

	dcache_tag_array u_tags (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_index (index),
		.rd_tag   (tag),
		.hit      (hit),
		.wr_en    (tag_wr_en),
		.wr_index (index),
		.wr_tag   (tag)
	);

	dcache_data_array u_data (
		.clk      (clk),
		.rd_index (index),
		.rd_word  (word),
		.rd_data  (rd_data),
		.wr_en    (data_wr_en),
		.wr_index (index),
		.wr_word  (data_wr_word),
		.wr_data  (data_wr_data)
	);

	dcache_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.addr         (addr),
		.rd_req       (rd_req),
		.wr_req       (wr_req),
		.wr_data      (wr_data),
		.rw_wait      (rw_wait),
		.hit          (hit),
		.tag_wr_en    (tag_wr_en),
		.data_wr_en   (data_wr_en),
		.data_wr_word (data_wr_word),
		.data_wr_data (data_wr_data),
		.bus          (dc_bus.master)
	);

	bus_arbiter u_arb (
		.clk       (clk),
		.rst_n     (rst_n),
		.m_dc      (dc_bus.arbiter),
		.if_req    (if_req),
		.if_addr   (if_addr),
		.if_ack    (if_ack),
		.if_rdata  (if_rdata),
		.if_ready  (if_ready),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready)
	);

endmodule

/* dv/dcache_asserts.sv */
// Concurrent checks on the cache controller's bus side, bound into every dcache_ctrl instance
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_asserts import dcache_pkg::*; (
	input logic        clk,
	input logic        rst_n,
	input logic [31:0] addr,
	input logic        rd_req,
	input logic        wr_req,
	input logic        rw_wait,
	input logic        tag_wr_en,
	input fill_state_e state,
	input logic        bus_ack,
	input logic        bus_rd,
	input logic        bus_wr,
	input logic        bus_ready,
	input logic [31:0] bus_addr
);
	int errors = 0; // Failed assertion count

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(bus_rd && bus_wr))
		else begin
			$error("bus rd and wr high in the same cycle");
			errors++;
		end

	a_cmd_needs_ack: assert property (@(posedge clk) disable iff (!rst_n)
		(bus_rd || bus_wr) |-> bus_ack)
		else begin
			$error("bus command issued without ack");
			errors++;
		end

	// Fill reads stay word-aligned inside the requested line and step one word per beat
	a_fill_addr: assert property (@(posedge clk) disable iff (!rst_n)
		(bus_rd && bus_ready && bus_addr[`DC_IDX_LSB-1:`DC_WORD_LSB] != 4'hf)
			##1 (bus_rd && $stable(addr[31:`DC_IDX_LSB]))
			|-> (bus_addr[1:0] == 2'b00)
			&& (bus_addr[31:`DC_IDX_LSB] == addr[31:`DC_IDX_LSB])
			&& (bus_addr[`DC_IDX_LSB-1:`DC_WORD_LSB]
				== $past(bus_addr[`DC_IDX_LSB-1:`DC_WORD_LSB]) + 4'd1))
		else begin
			$error("fill read address %08h outside line of %08h", bus_addr, addr);
			errors++;
		end

	// The filled line hits on the next cycle and releases the core
	a_hit_releases: assert property (@(posedge clk) disable iff (!rst_n)
		(tag_wr_en && rd_req && !wr_req)
			##1 (state == FILL && rd_req && !wr_req && $stable(addr))
			|-> !rw_wait)
		else begin
			$error("rw_wait still high after the filled line hit");
			errors++;
		end

endmodule

bind dcache_ctrl dcache_asserts u_asserts (
	.clk       (clk),
	.rst_n     (rst_n),
	.addr      (addr),
	.rd_req    (rd_req),
	.wr_req    (wr_req),
	.rw_wait   (rw_wait),
	.tag_wr_en (tag_wr_en),
	.state     (state),
	.bus_ack   (bus.ack),
	.bus_rd    (bus.rd),
	.bus_wr    (bus.wr),
	.bus_ready (bus.ready),
	.bus_addr  (bus.addr)
);

/* dv/tb_dcache_subsys.sv */
// Testbench for the cache subsystem, replaying the golden operation list against a memory model
`timescale 1ns/1ps

module tb_dcache_subsys;
	logic        clk;
	logic        rst_n;
	logic [31:0] addr;
	logic        rd_req;
	logic        wr_req;
	logic [31:0] wr_data;
	logic [31:0] rd_data;
	logic        rw_wait;
	logic        if_req;
	logic        if_ack;
	logic [31:0] if_addr;
	logic [31:0] if_rdata;
	logic        if_ready;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic        mem_rd;
	logic        mem_wr;
	logic [31:0] mem_rdata;
	logic        mem_ready;

	logic [31:0] mem_model [4096]; // Byte addresses 0x0000 to 0x3fff
	string       t_name [$];
	string       t_op [$];
	string       t_kind [$];
	logic [31:0] t_addr [$];
	logic [31:0] t_wdata [$];
	logic [31:0] t_exp [$];
	integer      seed;
	int          limit;
	int          cycles;
	int          n_pass;
	int          n_fail;
	int          bus_errors;
	int          total_fail;
	int          if_idx;
	logic        if_busy; // Background fetch in flight

	dcache_subsys dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.addr      (addr),
		.rd_req    (rd_req),
		.wr_req    (wr_req),
		.wr_data   (wr_data),
		.rd_data   (rd_data),
		.rw_wait   (rw_wait),
		.if_req    (if_req),
		.if_ack    (if_ack),
		.if_addr   (if_addr),
		.if_rdata  (if_rdata),
		.if_ready  (if_ready),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		for (int i = 0; i < 4096; i++) begin
			mem_model[i] = ~(32'(i) << 2); // Inverse of the byte address
		end
	end

	// Read data only while the bus reads
	assign mem_rdata = mem_rd ? mem_model[mem_addr[13:2]] : 'x;

	// Randomly gapped ready and write capture
	always @(posedge clk) begin
		mem_ready <= ($random(seed) & 3) != 0;
		if (mem_wr && mem_ready) begin
			mem_model[mem_addr[13:2]] <= mem_wdata;
		end
		if (rst_n && (mem_rd || mem_wr) && mem_addr[31:14] != '0) begin
			$display("Memory access at %08h lies outside the modelled range", mem_addr);
			bus_errors++;
		end
	end

	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run hung and was stopped after %0d cycles", cycles);
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic load_golden(output int count);
		int          fd;
		int          n;
		string       line;
		string       name;
		string       op;
		string       kind;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		count = 0;
		fd = $fopen("dv/dcache_golden.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) != 0) begin
					n = $sscanf(line, "%s %s %h %h %h %s", name, op, a, d, e, kind);
					if (n == 6 && name != "#") begin // Skip comment lines
						t_name.push_back(name);
						t_op.push_back(op);
						t_addr.push_back(a);
						t_wdata.push_back(d);
						t_exp.push_back(e);
						t_kind.push_back(kind);
						count++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic finish_test(input int i, input bit bad);
		if (bad) begin
			n_fail++;
		end else begin
			n_pass++;
			$display("ok   %s", t_name[i]);
		end
	endtask

	task automatic run_read(input int i);
		int          waited;
		logic [31:0] got;
		bit          bad;
		waited = 0;
		bad = 1'b0;
		@(posedge clk);
		addr   <= t_addr[i];
		rd_req <= 1'b1;
		@(posedge clk);
		while (rw_wait) begin
			waited++;
			@(posedge clk);
		end
		got = rd_data; // Sampled in the cycle rw_wait was low
		rd_req <= 1'b0;
		if (got !== t_exp[i]) begin
			$display("Fail %s: expected %08h, actual %08h", t_name[i], t_exp[i], got);
			bad = 1'b1;
		end
		if (t_kind[i] == "h" && waited != 0) begin
			$display("%s: cached read stalled for %0d cycles", t_name[i], waited);
			bad = 1'b1;
		end
		if (t_kind[i] == "m" && waited == 0) begin
			$display("%s: read returned at once although the line was not cached", t_name[i]);
			bad = 1'b1;
		end
		finish_test(i, bad);
	endtask

	task automatic run_write(input int i);
		@(posedge clk);
		addr    <= t_addr[i];
		wr_data <= t_wdata[i];
		wr_req  <= 1'b1;
		@(posedge clk);
		while (rw_wait) begin
			@(posedge clk);
		end
		wr_req <= 1'b0; // Beat landed on this edge
		finish_test(i, 1'b0);
	endtask

	task automatic run_ifetch(input int i);
		logic [31:0] got;
		@(posedge clk);
		if_addr <= t_addr[i];
		if_req  <= 1'b1;
		@(posedge clk);
		while (!(if_ack && if_ready)) begin
			@(posedge clk);
		end
		got = if_rdata;
		if_req <= 1'b0;
		if (got !== t_exp[i]) begin
			$display("Fail %s: expected %08h, actual %08h", t_name[i], t_exp[i], got);
			finish_test(i, 1'b1);
		end else begin
			finish_test(i, 1'b0);
		end
		if_busy = 1'b0;
	endtask

	task automatic run_reset(input int i);
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		finish_test(i, 1'b0);
	endtask

	initial begin
		int count;
		seed       = 32'h2fc0;
		rst_n      = 1'b0;
		addr       = '0;
		rd_req     = 1'b0;
		wr_req     = 1'b0;
		wr_data    = '0;
		if_req     = 1'b0;
		if_addr    = '0;
		mem_ready  = 1'b0;
		n_pass     = 0;
		n_fail     = 0;
		bus_errors = 0;
		if_busy    = 1'b0;
		limit      = 0;
		load_golden(count);
		if (count == 0) begin
			$display("Golden file could not be read or holds no tests");
			$display("RESULT: FAIL");
			$finish;
		end else begin
			limit = count * 64;
			repeat (8) @(posedge clk);
			rst_n <= 1'b1;
			for (int i = 0; i < count; i++) begin
				if (t_op[i] == "read") begin
					run_read(i);
				end else if (t_op[i] == "write") begin
					run_write(i);
				end else if (t_op[i] == "ifetch") begin
					wait (!if_busy);
					if_idx  = i;
					if_busy = 1'b1;
					fork
						run_ifetch(if_idx); // Overlaps the next data access
					join_none
				end else if (t_op[i] == "reset") begin
					wait (!if_busy);
					run_reset(i);
				end else begin
					$display("%s: unknown operation %s in golden file", t_name[i], t_op[i]);
					n_fail++;
				end
			end
			wait (!if_busy);
			@(posedge clk);
			total_fail = n_fail + bus_errors + dut.u_ctrl.u_asserts.errors;
			$display("Tests passed: %0d, failed: %0d, bus errors: %0d, assertion errors: %0d",
				n_pass, n_fail, bus_errors, dut.u_ctrl.u_asserts.errors);
			if (total_fail == 0) begin
				$display("RESULT: PASS");
			end else begin
				$display("RESULT: FAIL");
			end
			$finish;
		end
	end

endmodule

/* flist.f */
+incdir+verilog
verilog/dcache_pkg.sv
verilog/mem_bus_if.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_ctrl.sv
verilog/bus_arbiter.sv
verilog/dcache_subsys.sv
dv/dcache_asserts.sv
dv/tb_dcache_subsys.sv

/* dv/dcache_golden.txt */
# name op addr wdata expect stall, all numbers in hex
# stall: h must return without stalling, m must stall for a fill, x either way
rd_miss_first   read   00000104 00000000 fffffefb m
rd_hit_same     read   00000138 00000000 fffffec7 h
wr_hit          write  00000108 a5a50001 00000000 x
rd_after_wrhit  read   00000108 00000000 a5a50001 h
wr_miss         write  00000244 5a5a0002 00000000 x
rd_after_wrmiss read   00000244 00000000 5a5a0002 m
rd_same_line    read   00000240 00000000 fffffdbf h
evict_a         read   00000504 00000000 fffffafb m
evict_b         read   00000108 00000000 a5a50001 m
evict_c         read   00000d0c 00000000 fffff2f3 m
evict_d         read   00000104 00000000 fffffefb m
if_overlap      ifetch 00002000 00000000 ffffdfff x
dc_with_if      read   00000880 00000000 fffff77f m
if_written      ifetch 00000244 00000000 5a5a0002 x
rd_hit_880      read   000008bc 00000000 fffff743 h
mid_reset       reset  00000000 00000000 00000000 x
rd_after_rst    read   00000244 00000000 5a5a0002 m
rd_after_rst2   read   00000248 00000000 fffffdb7 h
wr_after_rst    write  00000248 12345678 00000000 x
rd_final        read   00000248 00000000 12345678 h
if_final        ifetch 00000248 00000000 12345678 x
